// ==== include/rename_macros.svh ====
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// Architectural register count (x0..x31)
`define RN_ARCH_REGS 32

// Physical register count
// The upper half seeds the free list after reset
`define RN_PHYS_REGS 64

// In-flight instruction IDs
// Must not exceed the number of free registers, so rename never stalls
`define RN_MAX_IDS 16

// Source operands renamed per instruction
`define RN_READ_PORTS 2

// Writeback groups tracked per mapping
`define RN_WB_GROUPS 2

`endif

// ==== rename_unit.f ====
+incdir+include
rtl/rename_pkg.sv
rtl/free_list_fifo.sv
rtl/map_table.sv
rtl/inflight_table.sv
rtl/renamer.sv
rtl/issue_stage.sv
rtl/rename_unit_top.sv
test/clock_gen.sv
test/rename_properties.sv
test/tb_rename_unit.sv

// ==== rtl/free_list_fifo.sv ====
`timescale 1ns/1ps
`include "rename_macros.svh"

module free_list_fifo (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  rename_pkg::phys_addr_t   push_data,
    input  logic                     pop,
    output rename_pkg::phys_addr_t   pop_data,
    input  logic                     undo_pop,
    output rename_pkg::free_count_t  count
);

    // One slot per register above the architectural set
    localparam int DEPTH = `RN_PHYS_REGS - `RN_ARCH_REGS;
    localparam int PTR_W = $clog2(DEPTH);

    rename_pkg::phys_addr_t storage [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;

    ////////////////////////////////////////////////////////////
    // Pointers
    // Pop and undo never coincide
    // (rename is blocked during a flush, undo only happens on flush)
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            else if (undo_pop)
                // Popped entry is still in storage, just step back over it
                rd_ptr <= rd_ptr - 1'b1;
        end
    end

    // Occupancy
    always_ff @(posedge clk) begin
        if (rst)
            count <= '0;
        else
            count <= count
                   + rename_pkg::free_count_t'(push)
                   + rename_pkg::free_count_t'(undo_pop)
                   - rename_pkg::free_count_t'(pop);
    end

    ////////////////////////////////////////////////////////////
    // Storage
    always_ff @(posedge clk) begin
        if (push)
            storage[wr_ptr] <= push_data;
    end

    // Head shown without a pop request
    assign pop_data = storage[rd_ptr];

endmodule

// ==== rtl/inflight_table.sv ====
`timescale 1ns/1ps
`include "rename_macros.svh"

module inflight_table (
    input  logic                         clk,
    // Written when an instruction with rd issues
    input  logic                         write_en,
    input  rename_pkg::inst_id_t         write_id,
    input  rename_pkg::inflight_entry_t  write_data,
    // Read by the retire port
    input  rename_pkg::inst_id_t         read_id,
    output rename_pkg::inflight_entry_t  read_data
);

    ////////////////////////////////////////////////////////////
    // One entry per instruction ID
    rename_pkg::inflight_entry_t mem [`RN_MAX_IDS];

    // Entries are only read for IDs that were written at issue
    always_ff @(posedge clk) begin
        if (write_en)
            mem[write_id] <= write_data;
    end

    // Combinational read, retire acts in the same cycle
    assign read_data = mem[read_id];

endmodule

// ==== rtl/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  rename_pkg::decode_req_t  decode,
    input  rename_pkg::inst_id_t     decode_id,
    input  rename_pkg::phys_addr_t   phys_rd,
    input  logic                     decode_advance,
    input  logic                     flush,
    input  logic                     issue_ready,
    output rename_pkg::issue_pkt_t   issue,
    output logic                     issue_fire
);

    logic valid_r;
    rename_pkg::inst_id_t id_r;
    logic uses_rd_r;
    rename_pkg::arch_addr_t rd_addr_r;
    rename_pkg::phys_addr_t phys_rd_r;

    ////////////////////////////////////////////////////////////
    // Occupancy
    // Flush wins over a load, the renamer drops that rename too
    always_ff @(posedge clk) begin
        if (rst)
            valid_r <= 1'b0;
        else if (flush)
            valid_r <= 1'b0;
        else if (decode_advance)
            valid_r <= 1'b1;
        else if (issue_fire)
            valid_r <= 1'b0;
    end

    // Payload
    always_ff @(posedge clk) begin
        if (decode_advance) begin
            id_r <= decode_id;
            uses_rd_r <= decode.uses_rd;
            rd_addr_r <= decode.rd_addr;
            phys_rd_r <= phys_rd;
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    assign issue = '{
        valid:   valid_r,
        id:      id_r,
        uses_rd: uses_rd_r,
        rd_addr: rd_addr_r,
        phys_rd: phys_rd_r
    };

    // A flushed instruction never issues
    assign issue_fire = valid_r & issue_ready & ~flush;

endmodule

// ==== rtl/map_table.sv ====
`timescale 1ns/1ps
`include "rename_macros.svh"

module map_table (
    input  logic                                              clk,
    // Source lookups from decode
    input  rename_pkg::arch_addr_t [`RN_READ_PORTS-1:0]       read_addr,
    output rename_pkg::map_entry_t [`RN_READ_PORTS-1:0]       read_data,
    // Single write port, source picked by the renamer
    input  logic                                              write_en,
    input  rename_pkg::arch_addr_t                            write_addr,
    input  rename_pkg::map_entry_t                            write_data,
    // Entry overwritten by the most recent write
    output rename_pkg::map_entry_t                            previous
);

    ////////////////////////////////////////////////////////////
    // Storage
    // Distributed RAM, one entry per architectural register
    rename_pkg::map_entry_t mem [`RN_ARCH_REGS];

    // Internal read port, always on the write address
    rename_pkg::map_entry_t write_port_old;

    assign write_port_old = mem[write_addr];

    always_ff @(posedge clk) begin
        if (write_en)
            mem[write_addr] <= write_data;
    end

    ////////////////////////////////////////////////////////////
    // Previous-entry register
    // Holds what the last write replaced
    // Used for rollback of the issue stage instruction
    // and recorded as the old mapping at issue
    always_ff @(posedge clk) begin
        if (write_en)
            previous <= write_port_old;
    end

    ////////////////////////////////////////////////////////////
    // Asynchronous source reads
    // A write shows up here from the next cycle on
    generate
        for (genvar i = 0; i < `RN_READ_PORTS; i++) begin : gen_read_ports
            assign read_data[i] = mem[read_addr[i]];
        end
    endgenerate

endmodule

// ==== rtl/rename_pkg.sv ====
`include "rename_macros.svh"

package rename_pkg;

    ////////////////////////////////////////////////////////////
    // Widths with a meaning
    typedef logic [$clog2(`RN_ARCH_REGS)-1:0] arch_addr_t;
    typedef logic [$clog2(`RN_PHYS_REGS)-1:0] phys_addr_t;
    typedef logic [$clog2(`RN_MAX_IDS)-1:0] inst_id_t;
    typedef logic [$clog2(`RN_WB_GROUPS)-1:0] wb_group_t;
    // One extra bit so a full list of 32 fits
    typedef logic [$clog2(`RN_ARCH_REGS):0] free_count_t;

    ////////////////////////////////////////////////////////////
    // Decode side
    typedef struct packed {
        logic uses_rd;
        arch_addr_t rd_addr;
        wb_group_t rd_wb_group;
        arch_addr_t [`RN_READ_PORTS-1:0] rs_addr;
    } decode_req_t;

    typedef struct packed {
        phys_addr_t [`RN_READ_PORTS-1:0] phys_rs;
        wb_group_t [`RN_READ_PORTS-1:0] rs_wb_group;
        phys_addr_t phys_rd;
    } rename_rsp_t;

    // Instruction waiting in the issue stage
    typedef struct packed {
        logic valid;
        inst_id_t id;
        logic uses_rd;
        arch_addr_t rd_addr;
        phys_addr_t phys_rd;
    } issue_pkt_t;

    typedef struct packed {
        logic valid;
        inst_id_t id;
        logic discard;
    } retire_pkt_t;

    ////////////////////////////////////////////////////////////
    // Table contents
    typedef struct packed {
        phys_addr_t phys_addr;
        wb_group_t wb_group;
    } map_entry_t;

    typedef struct packed {
        arch_addr_t rd_addr;
        phys_addr_t spec_phys_addr;
        phys_addr_t previous_phys_addr;
        wb_group_t previous_wb_group;
    } inflight_entry_t;

    // Post-reset table fill, then normal operation
    typedef enum logic {
        INIT_CLEAR,
        RUN
    } init_state_t;

endpackage

// ==== rtl/rename_unit_top.sv ====
`timescale 1ns/1ps

module rename_unit_top (
    input  logic                     clk,
    input  logic                     rst,
    input  rename_pkg::decode_req_t  decode,
    input  rename_pkg::inst_id_t     decode_id,
    input  logic                     decode_advance,
    input  logic                     issue_ready,
    input  logic                     flush,
    input  rename_pkg::retire_pkt_t  retire,
    output rename_pkg::rename_rsp_t  rename,
    output rename_pkg::issue_pkt_t   issue,
    output rename_pkg::free_count_t  free_count,
    output logic                     init_done
);

    logic issue_fire;

    ////////////////////////////////////////////////////////////
    // Issue register, takes phys_rd straight from rename
    issue_stage u_issue_stage (
        .clk            (clk),
        .rst            (rst),
        .decode         (decode),
        .decode_id      (decode_id),
        .phys_rd        (rename.phys_rd),
        .decode_advance (decode_advance),
        .flush          (flush),
        .issue_ready    (issue_ready),
        .issue          (issue),
        .issue_fire     (issue_fire)
    );

    // Map, free list and in-flight tracking
    renamer u_renamer (
        .clk            (clk),
        .rst            (rst),
        .decode         (decode),
        .decode_advance (decode_advance),
        .flush          (flush),
        .issue          (issue),
        .issue_fire     (issue_fire),
        .retire         (retire),
        .rename         (rename),
        .free_count     (free_count),
        .init_done      (init_done)
    );

endmodule

// ==== rtl/renamer.sv ====
`timescale 1ns/1ps
`include "rename_macros.svh"

module renamer (
    input  logic                     clk,
    input  logic                     rst,
    input  rename_pkg::decode_req_t  decode,
    input  logic                     decode_advance,
    input  logic                     flush,
    input  rename_pkg::issue_pkt_t   issue,
    input  logic                     issue_fire,
    input  rename_pkg::retire_pkt_t  retire,
    output rename_pkg::rename_rsp_t  rename,
    output rename_pkg::free_count_t  free_count,
    output logic                     init_done
);

    rename_pkg::init_state_t state;
    rename_pkg::arch_addr_t clear_index;
    logic init_clear;

    logic rename_valid;
    logic rollback;
    logic discard;

    rename_pkg::phys_addr_t free_head;
    rename_pkg::phys_addr_t free_push_data;

    rename_pkg::map_entry_t [`RN_READ_PORTS-1:0] map_read_data;
    rename_pkg::map_entry_t map_previous;
    logic map_wr_en;
    rename_pkg::arch_addr_t map_wr_addr;
    rename_pkg::map_entry_t map_wr_data;

    logic inflight_wr_en;
    rename_pkg::inflight_entry_t inflight_wr_data;
    rename_pkg::inflight_entry_t inflight_rd_data;

    ////////////////////////////////////////////////////////////
    // Init sequencer
    // Walks all architectural registers once after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rename_pkg::INIT_CLEAR;
            clear_index <= '0;
        end else if (state == rename_pkg::INIT_CLEAR) begin
            clear_index <= clear_index + 1'b1;
            if (clear_index == rename_pkg::arch_addr_t'(`RN_ARCH_REGS - 1))
                state <= rename_pkg::RUN;
        end
    end

    assign init_clear = (state == rename_pkg::INIT_CLEAR);
    assign init_done = (state == rename_pkg::RUN);

    ////////////////////////////////////////////////////////////
    // Control
    // x0 is never renamed
    assign discard = retire.valid & retire.discard;
    assign rename_valid = decode_advance & ~flush & ~discard
                        & decode.uses_rd & (|decode.rd_addr);
    // Undo the rename of the instruction sitting in issue
    assign rollback = flush & issue.valid & issue.uses_rd & (|issue.rd_addr);

    ////////////////////////////////////////////////////////////
    // Free list
    // Init seeds registers 32..63, retire returns one register
    assign free_push_data = init_clear
        ? rename_pkg::phys_addr_t'(`RN_ARCH_REGS) + rename_pkg::phys_addr_t'(clear_index)
        : (retire.discard ? inflight_rd_data.spec_phys_addr
                          : inflight_rd_data.previous_phys_addr);

    free_list_fifo u_free_list (
        .clk       (clk),
        .rst       (rst),
        .push      (init_clear | retire.valid),
        .push_data (free_push_data),
        .pop       (rename_valid),
        .pop_data  (free_head),
        .undo_pop  (rollback),
        .count     (free_count)
    );

    ////////////////////////////////////////////////////////////
    // Map write source
    // Priority init, rollback, discard, rename
    always_comb begin
        map_wr_en = init_clear | rollback | discard | rename_valid;
        map_wr_addr = decode.rd_addr;
        map_wr_data = '{phys_addr: free_head, wb_group: decode.rd_wb_group};
        if (init_clear) begin
            // Identity mapping
            map_wr_addr = clear_index;
            map_wr_data = '{phys_addr: rename_pkg::phys_addr_t'(clear_index), wb_group: '0};
        end else if (rollback) begin
            map_wr_addr = issue.rd_addr;
            map_wr_data = map_previous;
        end else if (discard) begin
            map_wr_addr = inflight_rd_data.rd_addr;
            map_wr_data = '{phys_addr: inflight_rd_data.previous_phys_addr,
                            wb_group: inflight_rd_data.previous_wb_group};
        end
    end

    map_table u_map_table (
        .clk        (clk),
        .read_addr  (decode.rs_addr),
        .read_data  (map_read_data),
        .write_en   (map_wr_en),
        .write_addr (map_wr_addr),
        .write_data (map_wr_data),
        .previous   (map_previous)
    );

    ////////////////////////////////////////////////////////////
    // In-flight metadata
    // Previous mapping is still the one this instruction's rename replaced
    assign inflight_wr_en = issue_fire & issue.uses_rd & (|issue.rd_addr);
    assign inflight_wr_data = '{
        rd_addr:            issue.rd_addr,
        spec_phys_addr:     issue.phys_rd,
        previous_phys_addr: map_previous.phys_addr,
        previous_wb_group:  map_previous.wb_group
    };

    inflight_table u_inflight_table (
        .clk        (clk),
        .write_en   (inflight_wr_en),
        .write_id   (issue.id),
        .write_data (inflight_wr_data),
        .read_id    (retire.id),
        .read_data  (inflight_rd_data)
    );

    ////////////////////////////////////////////////////////////
    // Rename results
    generate
        for (genvar i = 0; i < `RN_READ_PORTS; i++) begin : gen_rs
            assign rename.phys_rs[i] = (|decode.rs_addr[i]) ? map_read_data[i].phys_addr : '0;
            assign rename.rs_wb_group[i] = (|decode.rs_addr[i]) ? map_read_data[i].wb_group : '0;
        end
    endgenerate

    // Head of free list, zero for x0
    assign rename.phys_rd = (|decode.rd_addr) ? free_head : '0;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the rename unit testbench

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
sim_bin=sim_rename_unit

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rename_unit \
    -f rename_unit.f \
    --Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "SIMULATION PASSED" "$log_file"; then
    exit 0
fi
echo "No pass verdict found in $log_file"
exit 1

// ==== test/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst
);

    localparam int PERIOD_NS = 100;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Released just after the last reset edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// ==== test/rename_properties.sv ====
`timescale 1ns/1ps
`include "rename_macros.svh"

module rename_properties (
    input logic                     clk,
    input logic                     rst,
    input rename_pkg::decode_req_t  decode,
    input rename_pkg::rename_rsp_t  rename,
    input logic                     rollback,
    input logic                     discard,
    input rename_pkg::free_count_t  free_count
);

    ////////////////////////////////////////////////////////////
    // x0 is never renamed
    generate
        for (genvar i = 0; i < `RN_READ_PORTS; i++) begin : gen_zero_rs
            zero_rs_reads_zero: assert property (
                @(posedge clk) disable iff (rst)
                decode.rs_addr[i] == '0 |-> rename.phys_rs[i] == '0
            ) else $error("x0 source on port %0d renamed to p%0d", i, rename.phys_rs[i]);
        end
    endgenerate

    zero_rd_gets_zero: assert property (
        @(posedge clk) disable iff (rst)
        decode.rd_addr == '0 |-> rename.phys_rd == '0
    ) else $error("x0 destination got p%0d", rename.phys_rd);

    // Map write port serves one of these at a time
    no_rollback_with_discard: assert property (
        @(posedge clk) disable iff (rst)
        !(rollback && discard)
    ) else $error("Rollback and discard in the same cycle");

    // Free list depth
    free_count_bounded: assert property (
        @(posedge clk) disable iff (rst)
        free_count <= rename_pkg::free_count_t'(`RN_PHYS_REGS - `RN_ARCH_REGS)
    ) else $error("Free list count %0d above its depth", free_count);

endmodule

// ==== test/tb_rename_unit.sv ====
`timescale 1ns/1ps
`include "rename_macros.svh"

module tb_rename_unit;

    ////////////////////////////////////////////////////////////
    // Run length
    localparam int CLK_PERIOD_NS = 100;
    localparam int RESET_CYCLES = 4;
    localparam int INIT_CYCLES = `RN_ARCH_REGS;
    localparam int TEST_CYCLES = 200;
    localparam int TEST_COUNT = 5;
    localparam int MARGIN_CYCLES = 100;
    // Init wait allows twice the init length, then the identity sweep
    localparam int TOTAL_CYCLES = RESET_CYCLES + 3 * INIT_CYCLES + TEST_COUNT * TEST_CYCLES;
    localparam int WATCHDOG_NS = (TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS;

    logic clk;
    logic rst;
    rename_pkg::decode_req_t decode;
    rename_pkg::inst_id_t decode_id;
    logic decode_advance;
    logic issue_ready;
    logic flush;
    rename_pkg::retire_pkt_t retire;
    rename_pkg::rename_rsp_t rename;
    rename_pkg::issue_pkt_t issue;
    rename_pkg::free_count_t free_count;
    logic init_done;

    ////////////////////////////////////////////////////////////
    // Reference model
    rename_pkg::map_entry_t model_map [`RN_ARCH_REGS];
    rename_pkg::phys_addr_t model_free [$];
    rename_pkg::inflight_entry_t model_inflight [`RN_MAX_IDS];
    // Issued IDs with rd, oldest first
    rename_pkg::inst_id_t in_flight [$];
    logic id_busy [`RN_MAX_IDS];
    rename_pkg::issue_pkt_t model_issue;
    // Mapping replaced by the rename of the issue stage instruction
    rename_pkg::map_entry_t model_issue_prev;

    integer seed;
    int checks;
    int errors;
    logic verdict_printed;
    logic reuse_pending;
    rename_pkg::phys_addr_t reuse_phys;
    logic discard_seen;
    rename_pkg::arch_addr_t discarded_rd;

    clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    rename_unit_top u_dut (
        .clk            (clk),
        .rst            (rst),
        .decode         (decode),
        .decode_id      (decode_id),
        .decode_advance (decode_advance),
        .issue_ready    (issue_ready),
        .flush          (flush),
        .retire         (retire),
        .rename         (rename),
        .issue          (issue),
        .free_count     (free_count),
        .init_done      (init_done)
    );

    bind renamer rename_properties u_properties (
        .clk        (clk),
        .rst        (rst),
        .decode     (decode),
        .rename     (rename),
        .rollback   (rollback),
        .discard    (discard),
        .free_count (free_count)
    );

    ////////////////////////////////////////////////////////////
    // Helpers
    function automatic int unsigned rand_below(input int unsigned limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    function automatic logic chance(input int unsigned pct);
        return rand_below(100) < pct;
    endfunction

    // Lowest idle ID, -1 when all are in flight
    function automatic int first_free_id();
        for (int i = 0; i < `RN_MAX_IDS; i++) begin
            if (!id_busy[i])
                return i;
        end
        return -1;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before)
            $display("Test %s: ok", name);
        else
            $display("Test %s: %0d errors", name, errors - errors_before);
    endtask

    // Outputs against the model, sampled mid-cycle
    task automatic check_outputs();
        rename_pkg::map_entry_t src;
        for (int i = 0; i < `RN_READ_PORTS; i++) begin
            src = '0;
            if (decode.rs_addr[i] != '0)
                src = model_map[decode.rs_addr[i]];
            check_value(rename.phys_rs[i], src.phys_addr, "rs physical register");
            check_value(rename.rs_wb_group[i], src.wb_group, "rs writeback group");
        end
        if (decode.rd_addr == '0)
            check_value(rename.phys_rd, 0, "x0 destination register");
        else if (model_free.size() > 0)
            check_value(rename.phys_rd, model_free[0], "rd from free list head");
        check_value(issue.valid, model_issue.valid, "issue valid");
        if (model_issue.valid) begin
            check_value(issue.id, model_issue.id, "issue id");
            check_value(issue.uses_rd, model_issue.uses_rd, "issue uses_rd");
            check_value(issue.rd_addr, model_issue.rd_addr, "issue rd");
            check_value(issue.phys_rd, model_issue.phys_rd, "issue phys_rd");
        end
        check_value(free_count, model_free.size(), "free count");
        check_value(init_done, 1, "init done");
    endtask

    ////////////////////////////////////////////////////////////
    // One random cycle
    // Percent chances for decode, ready, flush, retire and discard
    task automatic run_cycle(input int unsigned p_decode, input int unsigned p_ready,
                             input int unsigned p_flush, input int unsigned p_retire,
                             input int unsigned p_discard);
        logic fire;
        logic rollback;
        logic renames;
        logic want_decode;
        int new_id;
        rename_pkg::phys_addr_t head;
        rename_pkg::inflight_entry_t done;

        @(posedge clk);
        #1;
        decode.uses_rd = rand_below(4) != 0;
        decode.rd_addr = rename_pkg::arch_addr_t'(rand_below(`RN_ARCH_REGS));
        decode.rd_wb_group = rename_pkg::wb_group_t'(rand_below(`RN_WB_GROUPS));
        for (int i = 0; i < `RN_READ_PORTS; i++)
            decode.rs_addr[i] = rename_pkg::arch_addr_t'(rand_below(`RN_ARCH_REGS));
        // Read back the register a discard just restored
        if (discard_seen)
            decode.rs_addr[0] = discarded_rd;
        discard_seen = 1'b0;
        issue_ready = chance(p_ready);
        flush = model_issue.valid && chance(p_flush);
        retire = '0;
        if (in_flight.size() > 0 && chance(p_retire)) begin
            retire.valid = 1'b1;
            // Youngest is discarded, oldest retires
            if (!model_issue.valid && chance(p_discard)) begin
                retire.discard = 1'b1;
                retire.id = in_flight[$];
            end else begin
                retire.id = in_flight[0];
            end
        end
        fire = model_issue.valid && issue_ready && !flush;
        new_id = first_free_id();
        want_decode = chance(p_decode);
        decode_advance = want_decode && new_id >= 0 && !flush
                       && !(retire.valid && retire.discard)
                       && (!model_issue.valid || fire);
        decode_id = (new_id >= 0) ? rename_pkg::inst_id_t'(new_id) : '0;

        @(negedge clk);
        check_outputs();
        check_value(u_dut.u_renamer.inflight_wr_en,
                    fire && model_issue.uses_rd && model_issue.rd_addr != '0,
                    "in-flight table write");
        renames = decode_advance && decode.uses_rd && decode.rd_addr != '0;
        if (renames && reuse_pending) begin
            check_value(rename.phys_rd, reuse_phys, "register reused after rollback");
            reuse_pending = 1'b0;
        end

        // Model state after the next edge
        rollback = flush && model_issue.valid && model_issue.uses_rd
                 && model_issue.rd_addr != '0;
        head = model_free[0];
        if (retire.valid) begin
            done = model_inflight[retire.id];
            if (retire.discard) begin
                model_free.push_back(done.spec_phys_addr);
                model_map[done.rd_addr] = '{phys_addr: done.previous_phys_addr,
                                            wb_group: done.previous_wb_group};
                discarded_rd = done.rd_addr;
                discard_seen = 1'b1;
                void'(in_flight.pop_back());
            end else begin
                model_free.push_back(done.previous_phys_addr);
                void'(in_flight.pop_front());
            end
            id_busy[retire.id] = 1'b0;
        end
        if (rollback) begin
            model_map[model_issue.rd_addr] = model_issue_prev;
            model_free.push_front(model_issue.phys_rd);
            reuse_phys = model_issue.phys_rd;
            reuse_pending = 1'b1;
        end
        if (fire) begin
            if (model_issue.uses_rd && model_issue.rd_addr != '0) begin
                model_inflight[model_issue.id] = '{
                    rd_addr:            model_issue.rd_addr,
                    spec_phys_addr:     model_issue.phys_rd,
                    previous_phys_addr: model_issue_prev.phys_addr,
                    previous_wb_group:  model_issue_prev.wb_group
                };
                in_flight.push_back(model_issue.id);
            end else begin
                id_busy[model_issue.id] = 1'b0;
            end
        end
        if (flush && model_issue.valid)
            id_busy[model_issue.id] = 1'b0;

        // Issue stage and rename
        if (flush) begin
            model_issue.valid = 1'b0;
        end else if (decode_advance) begin
            model_issue = '{
                valid:   1'b1,
                id:      decode_id,
                uses_rd: decode.uses_rd,
                rd_addr: decode.rd_addr,
                phys_rd: (decode.rd_addr != '0) ? head : '0
            };
            model_issue_prev = model_map[decode.rd_addr];
            id_busy[decode_id] = 1'b1;
            if (renames) begin
                model_map[decode.rd_addr] = '{phys_addr: head, wb_group: decode.rd_wb_group};
                void'(model_free.pop_front());
            end
        end else if (fire) begin
            model_issue.valid = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    initial begin
        int errors_before;
        int wait_cycles;

        seed = 32'ha883_9f7a;
        decode = '0;
        decode_id = '0;
        decode_advance = 1'b0;
        issue_ready = 1'b0;
        flush = 1'b0;
        retire = '0;
        checks = 0;
        errors = 0;
        verdict_printed = 1'b0;
        reuse_pending = 1'b0;
        reuse_phys = '0;
        discard_seen = 1'b0;
        discarded_rd = '0;
        model_issue = '0;
        model_issue_prev = '0;
        for (int i = 0; i < `RN_MAX_IDS; i++)
            id_busy[i] = 1'b0;

        // Init sequence after reset
        errors_before = errors;
        @(negedge rst);
        #1;
        check_value(init_done, 0, "init done right after reset");
        check_value(issue.valid, 0, "issue valid right after reset");
        wait_cycles = 0;
        while (!init_done && wait_cycles < 2 * INIT_CYCLES) begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        if (!init_done) begin
            errors++;
            $display("init_done never rose within %0d cycles of reset", wait_cycles);
        end else begin
            check_value(wait_cycles, INIT_CYCLES, "cycles until init done");
        end
        for (int i = 0; i < `RN_ARCH_REGS; i++)
            model_map[i] = '{phys_addr: rename_pkg::phys_addr_t'(i), wb_group: '0};
        for (int p = `RN_ARCH_REGS; p < `RN_PHYS_REGS; p++)
            model_free.push_back(rename_pkg::phys_addr_t'(p));
        // Identity mapping on both read ports
        for (int r = 0; r < `RN_ARCH_REGS; r++) begin
            @(posedge clk);
            #1;
            decode.rs_addr[0] = rename_pkg::arch_addr_t'(r);
            decode.rs_addr[1] = rename_pkg::arch_addr_t'(`RN_ARCH_REGS - 1 - r);
            @(negedge clk);
            check_value(rename.phys_rs[0], r, "identity map, port 0");
            check_value(rename.phys_rs[1], `RN_ARCH_REGS - 1 - r, "identity map, port 1");
            check_value(free_count, `RN_PHYS_REGS - `RN_ARCH_REGS, "free count after init");
        end
        report_test("init", errors_before);

        errors_before = errors;
        repeat (TEST_CYCLES) run_cycle(90, 100, 0, 30, 0);
        report_test("rename", errors_before);

        errors_before = errors;
        repeat (TEST_CYCLES) run_cycle(70, 90, 0, 60, 0);
        report_test("retire", errors_before);

        errors_before = errors;
        repeat (TEST_CYCLES) run_cycle(80, 70, 25, 40, 0);
        report_test("flush", errors_before);

        errors_before = errors;
        repeat (TEST_CYCLES) run_cycle(70, 80, 0, 50, 40);
        report_test("discard", errors_before);

        // Ready mostly low, issue must hold
        errors_before = errors;
        repeat (TEST_CYCLES) run_cycle(80, 25, 5, 40, 20);
        report_test("back-pressure", errors_before);

        $display("Checks: %0d, errors: %0d", checks, errors);
        verdict_printed = 1'b1;
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        verdict_printed = 1'b1;
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    // Run stopped before any verdict, such as by an assertion
    final begin
        if (!verdict_printed)
            $display("SIMULATION FAILED");
    end

endmodule
